// ==== include/pin_mux_defines.svh ====
// Pad count, mode width and APB bus width macros for the pin mux bank.
`ifndef PIN_MUX_DEFINES_SVH
`define PIN_MUX_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PAD_COUNT 8   // Pads in this bank.
`define MODE_W    2   // Four functions per pad.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Register index sits in paddr[4:2] and the upper bits must be zero.
`define APB_ADDR_W 8
`define APB_DATA_W 32

`endif

// ==== src/pin_mux_pkg.sv ====
// Pad mode enum, pad table constants and the APB, peripheral and pad bus structs.
`include "pin_mux_defines.svh"

package pin_mux_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Modes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [`MODE_W-1:0] {
		MODE_GPIO = 2'd0,
		MODE_CAN  = 2'd1,
		MODE_I2C  = 2'd2,
		MODE_UART = 2'd3
	} pad_mode_e;

	typedef pad_mode_e [`PAD_COUNT-1:0] pad_mode_vec_t;

	// Pad table. Pair p is pads 2p and 2p+1.
	// Even pad carries gpio bit 2p, can tx, i2c scl and uart rx.
	// Odd pad carries gpio bit 2p+1, can rx, i2c sda and uart tx.
	//   pair   can   i2c   uart
	//    0      0     0     0
	//    1      0     1     1
	//    2      1     1     0
	//    3      1     0     1
	// Bit p is the instance used by pair p.
	localparam logic [`PAD_COUNT/2-1:0] CAN_SEL  = 4'b1100;
	localparam logic [`PAD_COUNT/2-1:0] I2C_SEL  = 4'b0110;
	localparam logic [`PAD_COUNT/2-1:0] UART_SEL = 4'b1010;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Buses
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`APB_ADDR_W-1:0] paddr;
		logic [`APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`PAD_COUNT-1:0] gpio_o;
		logic [`PAD_COUNT-1:0] gpio_oe;
		logic [1:0]            can_tx;
		logic [1:0]            i2c_scl_o;
		logic [1:0]            i2c_scl_oe;
		logic [1:0]            i2c_sda_o;
		logic [1:0]            i2c_sda_oe;
		logic [1:0]            uart_tx;
	} periph_out_t;

	typedef struct packed {
		logic [`PAD_COUNT-1:0] gpio_i;
		logic [1:0]            can_rx;
		logic [1:0]            i2c_scl_i;
		logic [1:0]            i2c_sda_i;
		logic [1:0]            uart_rx;
	} periph_in_t;

	typedef struct packed {
		logic [`PAD_COUNT-1:0] pad_o;
		logic [`PAD_COUNT-1:0] pad_oe;
	} pad_drive_t;

endpackage

// ==== src/pin_mode_regs.sv ====
// APB mode register bank: one mode register per pad, read data captured in setup phase.
`timescale 1ns/1ps
`include "pin_mux_defines.svh"

module pin_mode_regs
	import pin_mux_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  apb_req_t               apb_i,
	output logic [`APB_DATA_W-1:0] prdata_o,
	output pad_mode_vec_t          modes_o
);

	logic                          setup;
	logic                          addr_ok;
	logic [$clog2(`PAD_COUNT)-1:0] idx;
	logic                          wr_en;
	logic                          rd_en;
	logic [`APB_DATA_W-1:0]        rd_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign setup   = apb_i.psel & ~apb_i.penable;
	assign addr_ok = (apb_i.paddr[`APB_ADDR_W-1:5] == '0);
	assign idx     = apb_i.paddr[4:2];      // Word index.
	assign wr_en   = setup & apb_i.pwrite & addr_ok;
	assign rd_en   = setup & ~apb_i.pwrite;

	// Zero-extended mode or zero outside the bank.
	always_comb begin
		rd_data = '0;
		if (addr_ok) begin
			rd_data[`MODE_W-1:0] = modes_o[idx];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PAD_COUNT; i++) begin
				modes_o[i] <= MODE_GPIO;
			end
		end else if (wr_en) begin
			modes_o[idx] <= pad_mode_e'(apb_i.pwdata[`MODE_W-1:0]);
		end
	end

	// Held until the next read setup phase.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prdata_o <= '0;
		end else if (rd_en) begin
			prdata_o <= rd_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Protocol checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (!rst_n) apb_i.penable |-> apb_i.psel
	) else $error("APB penable high without psel.");

	// Setup is always followed by its access phase.
	a_setup_to_access: assert property (
		@(posedge clk) disable iff (!rst_n) setup |=> (apb_i.psel & apb_i.penable)
	) else $error("APB setup phase not followed by access phase.");

endmodule

// ==== src/pad_out_select.sv ====
// Per-pad output value and output enable select by pad mode.
`timescale 1ns/1ps
`include "pin_mux_defines.svh"

module pad_out_select
	import pin_mux_pkg::*;
(
	input  pad_mode_vec_t modes_i,
	input  periph_out_t   periph_i,
	output pad_drive_t    drive_o
);

	// Per-pad candidates with the mode as bit index.
	logic [`PAD_COUNT-1:0][(2**`MODE_W)-1:0] opt_o;
	logic [`PAD_COUNT-1:0][(2**`MODE_W)-1:0] opt_oe;
	logic [`PAD_COUNT-1:0]                   pad_o;
	logic [`PAD_COUNT-1:0]                   pad_oe;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pad table, output side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar p = 0; p < `PAD_COUNT/2; p++) begin : gen_pair
		// Even pad. UART slot is rx, so input only.
		assign opt_o[2*p]  = {1'b0,
				periph_i.i2c_scl_o[I2C_SEL[p]],
				periph_i.can_tx[CAN_SEL[p]],
				periph_i.gpio_o[2*p]};
		assign opt_oe[2*p] = {1'b0,
				periph_i.i2c_scl_oe[I2C_SEL[p]],
				1'b1,
				periph_i.gpio_oe[2*p]};

		// Odd pad. CAN slot is rx, so input only.
		assign opt_o[2*p+1]  = {periph_i.uart_tx[UART_SEL[p]],
				periph_i.i2c_sda_o[I2C_SEL[p]],
				1'b0,
				periph_i.gpio_o[2*p+1]};
		assign opt_oe[2*p+1] = {1'b1,
				periph_i.i2c_sda_oe[I2C_SEL[p]],
				1'b0,
				periph_i.gpio_oe[2*p+1]};
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Select by mode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar n = 0; n < `PAD_COUNT; n++) begin : gen_pad
		assign pad_o[n]  = opt_o[n][modes_i[n]];
		assign pad_oe[n] = opt_oe[n][modes_i[n]];
	end

	assign drive_o = '{pad_o: pad_o, pad_oe: pad_oe};

endmodule

// ==== src/pad_in_route.sv ====
// Pad input routing to peripheral inputs with idle defaults and last-pad priority.
`timescale 1ns/1ps
`include "pin_mux_defines.svh"

module pad_in_route
	import pin_mux_pkg::*;
(
	input  pad_mode_vec_t         modes_i,
	input  logic [`PAD_COUNT-1:0] pad_i,
	output periph_in_t            periph_o
);

	// One-hot function select per pad with the mode as bit index.
	logic [`PAD_COUNT-1:0][(2**`MODE_W)-1:0] sel_oh;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mode decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int n = 0; n < `PAD_COUNT; n++) begin
			case (modes_i[n])
				MODE_GPIO: sel_oh[n] = 4'b0001;
				MODE_CAN:  sel_oh[n] = 4'b0010;
				MODE_I2C:  sel_oh[n] = 4'b0100;
				MODE_UART: sel_oh[n] = 4'b1000;
				default:   sel_oh[n] = 4'b0000;  // Unknown mode selects nothing.
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Routing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		// Idle values. I2C lines float high.
		periph_o.gpio_i    = '0;
		periph_o.can_rx    = '0;
		periph_o.i2c_scl_i = '1;
		periph_o.i2c_sda_i = '1;
		periph_o.uart_rx   = '0;

		// Ascending walk lets the highest pad win a shared input.
		for (int n = 0; n < `PAD_COUNT; n++) begin
			if (sel_oh[n][MODE_GPIO]) periph_o.gpio_i[n] = pad_i[n];
			if (n % 2 == 0) begin
				if (sel_oh[n][MODE_I2C]) begin
					periph_o.i2c_scl_i[I2C_SEL[n/2]] = pad_i[n];
				end
				if (sel_oh[n][MODE_UART]) begin
					periph_o.uart_rx[UART_SEL[n/2]] = pad_i[n];
				end
			end else begin
				if (sel_oh[n][MODE_CAN]) begin
					periph_o.can_rx[CAN_SEL[n/2]] = pad_i[n];
				end
				if (sel_oh[n][MODE_I2C]) begin
					periph_o.i2c_sda_i[I2C_SEL[n/2]] = pad_i[n];
				end
			end
		end
	end

endmodule

// ==== src/pin_mux_top.sv ====
// Pin mux top: APB mode register bank with output select and input routing.
`timescale 1ns/1ps
`include "pin_mux_defines.svh"

module pin_mux_top
	import pin_mux_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	// APB.
	input  apb_req_t               apb_i,
	output logic [`APB_DATA_W-1:0] prdata_o,

	// Peripheral side.
	input  periph_out_t            periph_out_i,
	output periph_in_t             periph_in_o,

	// Pad ring.
	input  logic [`PAD_COUNT-1:0]  pad_i,
	output pad_drive_t             pad_drive_o
);

	pad_mode_vec_t modes;

	pin_mode_regs u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.apb_i    (apb_i),
		.prdata_o (prdata_o),
		.modes_o  (modes)
	);

	// Pad paths below are purely combinational.
	pad_out_select u_out_sel (
		.modes_i  (modes),
		.periph_i (periph_out_i),
		.drive_o  (pad_drive_o)
	);

	pad_in_route u_in_route (
		.modes_i  (modes),
		.pad_i    (pad_i),
		.periph_o (periph_in_o)
	);

endmodule

// ==== sim/pin_mux_checker.sv ====
// Shadow mode model, pad table reference and concurrent checks on the pin mux ports.
`timescale 1ns/1ps
`include "pin_mux_defines.svh"

module pin_mux_checker
	import pin_mux_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  apb_req_t               apb_i,
	input  logic [`APB_DATA_W-1:0] prdata_i,
	input  periph_out_t            periph_out_i,
	input  periph_in_t             periph_in_i,
	input  logic [`PAD_COUNT-1:0]  pad_i,
	input  pad_drive_t             pad_drive_i,
	output logic                   failed_o
);

	typedef logic [`PAD_COUNT-1:0][`MODE_W-1:0] mode_arr_t;

	// Peripheral instance used by each pad pair.
	localparam int CAN_OF[4]  = '{0, 0, 1, 1};
	localparam int I2C_OF[4]  = '{0, 1, 1, 0};
	localparam int UART_OF[4] = '{0, 1, 0, 1};

	mode_arr_t              shadow;
	logic [`APB_DATA_W-1:0] exp_prdata;
	pad_drive_t             exp_drive;
	periph_in_t             exp_in;
	logic                   setup;
	logic                   in_bank;
	logic                   failed = 1'b0;

	assign setup    = apb_i.psel && !apb_i.penable;
	assign in_bank  = (apb_i.paddr[`APB_ADDR_W-1:5] == '0);
	assign failed_o = failed;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic pad_drive_t expect_drive(input mode_arr_t m, input periph_out_t po);
		pad_drive_t d;
		int         p;
		d = '0;
		for (int n = 0; n < `PAD_COUNT; n++) begin
			p = n / 2;
			case (m[n])
				MODE_GPIO: {d.pad_oe[n], d.pad_o[n]} = {po.gpio_oe[n], po.gpio_o[n]};
				MODE_CAN:  if (n % 2 == 0)
					{d.pad_oe[n], d.pad_o[n]} = {1'b1, po.can_tx[CAN_OF[p]]};
				MODE_I2C:  {d.pad_oe[n], d.pad_o[n]} = (n % 2 == 0) ?
					{po.i2c_scl_oe[I2C_OF[p]], po.i2c_scl_o[I2C_OF[p]]} :
					{po.i2c_sda_oe[I2C_OF[p]], po.i2c_sda_o[I2C_OF[p]]};
				MODE_UART: if (n % 2 == 1)
					{d.pad_oe[n], d.pad_o[n]} = {1'b1, po.uart_tx[UART_OF[p]]};
			endcase
		end
		return d;
	endfunction

	// Highest pad first so the first pad to claim an input keeps it.
	function automatic periph_in_t expect_in(input mode_arr_t m,
			input logic [`PAD_COUNT-1:0] pads);
		periph_in_t e;
		periph_in_t hit;
		int         p;
		e = '0;
		e.i2c_scl_i = '1;   // I2C idles high.
		e.i2c_sda_i = '1;
		hit = '0;
		for (int n = `PAD_COUNT - 1; n >= 0; n--) begin
			p = n / 2;
			case (m[n])
				MODE_GPIO: e.gpio_i[n] = pads[n];
				MODE_CAN:  if (n % 2 == 1 && !hit.can_rx[CAN_OF[p]])
					{hit.can_rx[CAN_OF[p]], e.can_rx[CAN_OF[p]]} = {1'b1, pads[n]};
				MODE_I2C: begin
					if (n % 2 == 0 && !hit.i2c_scl_i[I2C_OF[p]])
						{hit.i2c_scl_i[I2C_OF[p]], e.i2c_scl_i[I2C_OF[p]]} = {1'b1, pads[n]};
					if (n % 2 == 1 && !hit.i2c_sda_i[I2C_OF[p]])
						{hit.i2c_sda_i[I2C_OF[p]], e.i2c_sda_i[I2C_OF[p]]} = {1'b1, pads[n]};
				end
				MODE_UART: if (n % 2 == 0 && !hit.uart_rx[UART_OF[p]])
					{hit.uart_rx[UART_OF[p]], e.uart_rx[UART_OF[p]]} = {1'b1, pads[n]};
			endcase
		end
		return e;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shadow     <= '0;   // All pads GPIO.
			exp_prdata <= '0;
		end else if (setup && apb_i.pwrite && in_bank) begin
			shadow[apb_i.paddr[4:2]] <= apb_i.pwdata[`MODE_W-1:0];
		end else if (setup && !apb_i.pwrite) begin
			exp_prdata <= '0;
			if (in_bank) exp_prdata[`MODE_W-1:0] <= shadow[apb_i.paddr[4:2]];
		end
	end

	always_comb begin
		exp_drive = expect_drive(shadow, periph_out_i);
		exp_in    = expect_in(shadow, pad_i);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic flag_failure(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		failed = 1'b1;
	endtask

	a_pad_drive: assert property (@(posedge clk) disable iff (!rst_n) pad_drive_i == exp_drive)
		else flag_failure($sformatf("pad drive %h, expected %h", pad_drive_i, exp_drive));

	a_periph_in: assert property (@(posedge clk) disable iff (!rst_n) periph_in_i == exp_in)
		else flag_failure($sformatf("peripheral inputs %h, expected %h", periph_in_i, exp_in));

	a_prdata: assert property (@(posedge clk) disable iff (!rst_n) prdata_i == exp_prdata)
		else flag_failure($sformatf("prdata %h, expected %h", prdata_i, exp_prdata));

endmodule

// ==== sim/tb_pin_mux.sv ====
// Testbench top: clock, reset, seeded APB and pad stimulus, DUT and checker.
`timescale 1ns/1ps
`include "pin_mux_defines.svh"

module tb_pin_mux
	import pin_mux_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int RUN_LIMIT    = 5000;   // Watchdog in clock cycles.

	logic                   clk;
	logic                   rst_n;
	apb_req_t               apb;
	logic [`APB_DATA_W-1:0] prdata;
	periph_out_t            periph_out;
	periph_in_t             periph_in;
	logic [`PAD_COUNT-1:0]  pad_in;
	pad_drive_t             pad_drive;
	logic                   check_failed;

	always #20 clk = ~clk;   // 40 ns period.

	pin_mux_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.apb_i        (apb),
		.prdata_o     (prdata),
		.periph_out_i (periph_out),
		.periph_in_o  (periph_in),
		.pad_i        (pad_in),
		.pad_drive_o  (pad_drive)
	);

	pin_mux_checker u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.apb_i        (apb),
		.prdata_i     (prdata),
		.periph_out_i (periph_out),
		.periph_in_i  (periph_in),
		.pad_i        (pad_in),
		.pad_drive_i  (pad_drive),
		.failed_o     (check_failed)
	);

	// Fresh peripheral and pad values on each falling edge.
	task automatic next_cycle();
		logic [31:0] r_out;
		logic [31:0] r_pad;
		@(negedge clk);
		r_out      = $urandom;
		r_pad      = $urandom;
		periph_out = r_out[$bits(periph_out_t)-1:0];
		pad_in     = r_pad[`PAD_COUNT-1:0];
	endtask

	// Setup phase and access phase, then idle.
	task automatic apb_transfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
			input logic [`APB_DATA_W-1:0] data);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
		next_cycle();
		apb.penable = 1'b1;
		next_cycle();
		apb.psel    = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr,
			input logic [`APB_DATA_W-1:0] data);
		apb_transfer(1'b1, addr, data);
	endtask

	task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr);
		apb_transfer(1'b0, addr, $urandom);
	endtask

	// Address with nonzero upper bits.
	function automatic logic [`APB_ADDR_W-1:0] outside_addr(input logic [31:0] r);
		return {(r[7:5] == 3'b000) ? 3'b100 : r[7:5], r[2:0], 2'b00};
	endfunction

	always @(posedge check_failed) begin
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at the first failed check.");
	end

	initial begin
		for (int i = 0; i < RUN_LIMIT; i++) @(posedge clk);
		$display("Timeout: the test sequence did not finish within %0d cycles.", RUN_LIMIT);
		$display("SIMULATION FAILED");
		$fatal(1, "Watchdog expired.");
	end

	initial begin
		logic [31:0] r;
		void'($urandom(32'hf203_a712));
		clk        = 1'b0;
		rst_n      = 1'b0;
		apb        = '0;
		periph_out = '0;
		pad_in     = '0;
		for (int i = 0; i < RESET_CYCLES; i++) next_cycle();
		rst_n = 1'b1;

		// Read reset values and write then read back each register.
		for (int i = 0; i < `PAD_COUNT; i++) apb_read({3'b000, i[2:0], 2'b00});
		for (int i = 0; i < `PAD_COUNT; i++) begin
			apb_write({3'b000, i[2:0], 2'b00}, $urandom);
			apb_read({3'b000, i[2:0], 2'b00});
		end

		// No mode changes and zero reads outside the bank.
		for (int i = 0; i < `PAD_COUNT; i++) begin
			r = $urandom;
			apb_write(outside_addr(r), $urandom);
			apb_read(outside_addr(r));
			apb_read({3'b000, r[2:0], 2'b00});
		end

		// Random modes with random pad traffic.
		for (int i = 0; i < 600; i++) begin
			r = $urandom;
			case (r[10:8])
				3'd0:    apb_read({3'b000, r[2:0], 2'b00});
				3'd1:    apb_write(outside_addr(r), $urandom);
				default: apb_write({3'b000, r[2:0], 2'b00}, $urandom);
			endcase
		end

		next_cycle();
		if (check_failed) begin
			$display("SIMULATION FAILED");
			$fatal(1, "Checker reported an error.");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+include
src/pin_mux_pkg.sv
src/pin_mode_regs.sv
src/pad_out_select.sv
src/pad_in_route.sv
src/pin_mux_top.sv
sim/pin_mux_checker.sv
sim/tb_pin_mux.sv

// ==== Makefile ====
# Verilator build, run and lint for the pin mux testbench.

VERILATOR ?= verilator
TOP       ?= tb_pin_mux
RTL_TOP   ?= pin_mux_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG) || { echo "Pass line missing from $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timescale 1ns/1ps --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
